// File: fetch_top.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/axi_pkg.sv
hdl/fetch_rsp_if.sv
hdl/pc_gen.sv
hdl/axi_fetch_port.sv
hdl/inst_predecode.sv
hdl/fetch_top.sv
test/axi_mem_model.sv
test/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/axi_pkg.sv
      - hdl/fetch_rsp_if.sv
      - hdl/pc_gen.sv
      - hdl/axi_fetch_port.sv
      - hdl/inst_predecode.sv
      - hdl/fetch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/axi_mem_model.sv
      - test/fetch_tb.sv

// File: test/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import axi_pkg::*;

    localparam logic [`FETCH_ADDR_W-1:0] base_pc    = `FETCH_RESET_PC;
    localparam int                       wait_limit = 200;

    // One row per expected output
    // A redirect targets the row's own pc
    typedef struct {
        string                    name;
        logic                     redirect;
        logic                     replay;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [31:0]              inst;
        inst_class_e              cls;
        logic [31:0]              imm;
        logic                     fault;
    } row_t;

    row_t rows [$];

    logic                       clock;
    logic                       reset;
    logic                       arvalid;
    logic                       arready;
    logic [`FETCH_ADDR_W-1:0]   araddr;
    logic [`FETCH_AXI_ID_W-1:0] arid;
    logic [7:0]                 arlen;
    logic [2:0]                 arsize;
    logic [1:0]                 arburst;
    logic                       rvalid;
    logic [31:0]                rdata;
    axi_resp_e                  rresp;
    logic                       rlast;
    logic [`FETCH_AXI_ID_W-1:0] rid;
    logic                       rready;
    logic                       out_valid;
    logic                       out_ready;
    logic [`FETCH_ADDR_W-1:0]   out_pc;
    logic [31:0]                out_inst;
    inst_class_e                out_class;
    logic [31:0]                out_imm;
    logic                       out_fault;
    logic                       redirect_valid;
    logic [`FETCH_ADDR_W-1:0]   redirect_pc;
    logic                       replay;

    fetch_top uut (.*);

    // Fault window covers the words at offsets c0 to cc
    axi_mem_model #(
        .fault_lo (base_pc + 32'hC0),
        .fault_hi (base_pc + 32'hD0)
    ) u_mem (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_addr(input string name, input logic [`FETCH_ADDR_W-1:0] expected,
                              input logic [`FETCH_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s pc: expected %h actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s inst: expected %h actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_class(input string name, input inst_class_e expected,
                               input inst_class_e actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s class: expected %s actual %s",
                                     name, expected.name(), actual.name()));
        end
    endtask

    task automatic check_imm(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s imm: expected %h actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_fault(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s fault: expected %b actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic compare_row(input int idx);
        check_addr(rows[idx].name, rows[idx].pc, out_pc);
        check_word(rows[idx].name, rows[idx].inst, out_inst);
        check_class(rows[idx].name, rows[idx].cls, out_class);
        check_imm(rows[idx].name, rows[idx].imm, out_imm);
        check_fault(rows[idx].name, rows[idx].fault, out_fault);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    task automatic add_row(input string name, input logic redirect, input logic replay_req,
                           input logic [11:0] offset, input logic [31:0] inst,
                           input inst_class_e cls, input logic [31:0] imm, input logic fault);
        row_t row;
        row = '{name, redirect, replay_req, base_pc + offset, inst, cls, imm, fault};
        rows.push_back(row);
    endtask

    task automatic fill_table();
        add_row("reset_pc",        0, 0, 'h00, 32'hFFF0_0093, cls_alu,     32'hFFFF_FFFF, 0);
        add_row("step_load",       0, 0, 'h04, 32'hFF80_A103, cls_load,    32'hFFFF_FFF8, 0);
        add_row("step_store",      0, 0, 'h08, 32'hFE31_2E23, cls_store,   32'hFFFF_FFFC, 0);
        add_row("step_branch",     0, 0, 'h0C, 32'hFE20_88E3, cls_branch,  32'hFFFF_FFF0, 0);
        add_row("redirect_jal",    1, 0, 'h40, 32'hFF9F_F0EF, cls_jal,     32'hFFFF_FFF8, 0);
        add_row("replay_jal",      0, 1, 'h40, 32'hFF9F_F0EF, cls_jal,     32'hFFFF_FFF8, 0);
        add_row("redirect_replay", 1, 1, 'h80, 32'h0040_8067, cls_jalr,    32'h0000_0004, 0);
        add_row("step_lui",        0, 0, 'h84, 32'h8000_02B7, cls_alu,     32'h8000_0000, 0);
        add_row("step_auipc",      0, 0, 'h88, 32'h1234_5317, cls_alu,     32'h1234_5000, 0);
        add_row("step_op",         0, 0, 'h8C, 32'h0020_83B3, cls_alu,     32'h0000_0000, 0);
        add_row("step_system",     0, 0, 'h90, 32'h0000_0073, cls_system,  32'h0000_0000, 0);
        add_row("compressed_word", 0, 0, 'h94, 32'h0000_4501, cls_illegal, 32'h0000_0000, 0);
        add_row("unknown_opcode",  0, 0, 'h98, 32'h0FF0_000F, cls_illegal, 32'h0000_0000, 0);
        add_row("fault_window",    1, 0, 'hC0, 32'h0000_0000, cls_illegal, 32'h0000_0000, 1);
        add_row("fault_step",      0, 0, 'hC4, 32'h0000_0000, cls_illegal, 32'h0000_0000, 1);
        add_row("redirect_back",   1, 0, 'h10, 32'h7FF5_0513, cls_alu,     32'h0000_07FF, 0);
    endtask

    // Fault rows keep the background word in memory
    task automatic load_memory();
        foreach (rows[i]) begin
            if (!rows[i].fault) begin
                u_mem.load_word(rows[i].pc, rows[i].inst);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Handshake helpers
    // ------------------------------------------------------------------------
    task automatic wait_for_output(input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!out_valid) begin
            cycles++;
            if (cycles > wait_limit) begin
                report_failure($sformatf("no output arrived for test %s", name));
            end
            @(negedge clock);
        end
    endtask

    // One-cycle pulse while the previous output is still held
    task automatic apply_request(input int idx);
        @(posedge clock);
        redirect_valid <= rows[idx].redirect;
        redirect_pc    <= rows[idx].pc;
        replay         <= rows[idx].replay;
        @(posedge clock);
        redirect_valid <= 1'b0;
        replay         <= 1'b0;
    endtask

    // Random back-pressure with outputs rechecked every cycle until taken
    task automatic consume_output(input int idx);
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clock);
            if (!out_valid) begin
                report_failure($sformatf("out_valid dropped before the handshake in test %s",
                                         rows[idx].name));
            end
            compare_row(idx);
            taken = out_ready;
            @(posedge clock);
            out_ready <= taken ? 1'b0 : ($urandom_range(3, 0) == 0);
            cycles++;
            if (cycles > wait_limit) begin
                report_failure($sformatf("decode never took the output of test %s",
                                         rows[idx].name));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h75474986));
        reset          = 1'b1;
        out_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        replay         = 1'b0;
        fill_table();
        @(posedge clock);
        load_memory();
        @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            wait_for_output(rows[i].name);
            compare_row(i);
            if (i + 1 < rows.size()) begin
                apply_request(i + 1);
            end
            consume_output(i);
            // Each word is handed over once
            @(negedge clock);
            if (out_valid) begin
                report_failure($sformatf("output repeated after the handshake in test %s",
                                         rows[i].name));
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: test/axi_mem_model.sv
`include "fetch_params.svh"

module axi_mem_model #(
    parameter logic [`FETCH_ADDR_W-1:0] fault_lo = '0,
    parameter logic [`FETCH_ADDR_W-1:0] fault_hi = '0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`FETCH_ADDR_W-1:0]   araddr,
    input  logic [`FETCH_AXI_ID_W-1:0] arid,
    input  logic [7:0]                 arlen,
    input  logic [2:0]                 arsize,
    input  logic [1:0]                 arburst,
    output logic                       rvalid,
    output logic [31:0]                rdata,
    output axi_pkg::axi_resp_e         rresp,
    output logic                       rlast,
    output logic [`FETCH_AXI_ID_W-1:0] rid,
    input  logic                       rready
);

    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;

    logic [31:0]              mem [64];
    logic                     busy;
    logic                     bad_req;
    logic                     in_window;
    logic [`FETCH_ADDR_W-1:0] addr_q;
    int unsigned              delay;

    // Background pattern that the testbench table overwrites
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hA5A5_0000 ^ (i << 2);
        end
    end

    task automatic load_word(input logic [`FETCH_ADDR_W-1:0] addr, input logic [31:0] data);
        mem[addr[7:2]] = data;
    endtask

    assign rlast     = 1'b1;
    assign in_window = (addr_q >= fault_lo) && (addr_q < fault_hi);

    // ------------------------------------------------------------------------
    // One read at a time with random latency and the response held until rready
    // ------------------------------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            busy    <= 1'b0;
            rdata   <= '0;
            rresp   <= okay;
            rid     <= '0;
        end else if (!busy) begin
            arready <= 1'b1;
            if (arvalid && arready) begin
                arready <= 1'b0;
                busy    <= 1'b1;
                addr_q  <= araddr;
                rid     <= arid;
                // Only single-beat word reads with ID zero are served
                bad_req <= (arlen != 8'd0) || (arsize != AXI_SIZE_4B) ||
                           (arburst != fixed) || (arid != '0);
                delay   <= $urandom_range(5, 0);
            end
        end else if (!rvalid) begin
            if (delay == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[addr_q[7:2]];
                rresp  <= bad_req ? decerr : (in_window ? slverr : okay);
            end else begin
                delay <= delay - 1;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
            busy   <= 1'b0;
        end
    end

endmodule

// File: hdl/fetch_top.sv
`include "fetch_params.svh"

module fetch_top (
    input  logic                       clock,
    input  logic                       reset,

    // ------------------------------------------------------------------------
    // AXI4 read address channel
    // ------------------------------------------------------------------------
    input  logic                       arready,
    output logic                       arvalid,
    output logic [`FETCH_ADDR_W-1:0]   araddr,
    output logic [`FETCH_AXI_ID_W-1:0] arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,

    // ------------------------------------------------------------------------
    // AXI4 read data channel
    // ------------------------------------------------------------------------
    input  logic                       rvalid,
    input  logic [31:0]                rdata,
    input  axi_pkg::axi_resp_e         rresp,
    input  logic                       rlast,
    input  logic [`FETCH_AXI_ID_W-1:0] rid,
    output logic                       rready,

    // ------------------------------------------------------------------------
    // Toward decode
    // ------------------------------------------------------------------------
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`FETCH_ADDR_W-1:0]   out_pc,
    output logic [31:0]                out_inst,
    output rv_isa_pkg::inst_class_e    out_class,
    output logic [31:0]                out_imm,
    output logic                       out_fault,

    // From later stages
    input  logic                       redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0]   redirect_pc,
    input  logic                       replay
);

    logic [`FETCH_ADDR_W-1:0] fetch_addr;
    logic                     fetch_req;
    logic                     fetch_issue;
    logic                     retire;

    // Fetched word between bus port and predecoder
    fetch_rsp_if rsp_if ();

    pc_gen u_pc_gen (
        .clock          (clock),
        .reset          (reset),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .replay         (replay),
        .fetch_issue    (fetch_issue),
        .fetch_addr     (fetch_addr),
        .fetch_req      (fetch_req)
    );

    axi_fetch_port u_axi_fetch_port (
        .clock       (clock),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_issue (fetch_issue),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid),
        .rready      (rready),
        .rsp         (rsp_if.source)
    );

    inst_predecode u_inst_predecode (
        .clock     (clock),
        .reset     (reset),
        .rsp       (rsp_if.sink),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_class (out_class),
        .out_imm   (out_imm),
        .out_fault (out_fault),
        .retire    (retire)
    );

endmodule

// File: hdl/inst_predecode.sv
`include "fetch_params.svh"

module inst_predecode (
    input  logic                     clock,
    input  logic                     reset,
    fetch_rsp_if.sink                rsp,
    input  logic                     out_ready,
    output logic                     out_valid,
    output logic [`FETCH_ADDR_W-1:0] out_pc,
    output logic [31:0]              out_inst,
    output rv_isa_pkg::inst_class_e  out_class,
    output logic [31:0]              out_imm,
    output logic                     out_fault,
    output logic                     retire
);

    import rv_isa_pkg::*;

    rv_inst_t    inst;
    inst_class_e cls;
    logic [31:0] imm;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        accept;

    assign inst = rsp.word;

    // ------------------------------------------------------------------------
    // Immediates, sign extended, one per format
    // ------------------------------------------------------------------------
    assign imm_i = {{20{inst.itype.imm[11]}}, inst.itype.imm};
    assign imm_s = {{20{inst.stype.imm_hi[6]}}, inst.stype.imm_hi, inst.stype.imm_lo};
    assign imm_b = {{20{inst.btype.imm12}}, inst.btype.imm11, inst.btype.imm10_5,
                    inst.btype.imm4_1, 1'b0};
    assign imm_u = {inst.utype.imm, 12'b0};
    assign imm_j = {{12{inst.jtype.imm20}}, inst.jtype.imm19_12, inst.jtype.imm11,
                    inst.jtype.imm10_1, 1'b0};

    // ------------------------------------------------------------------------
    // Class and immediate selection
    // ------------------------------------------------------------------------
    always_comb begin
        cls = cls_illegal;
        imm = '0;
        // Compressed encodings are not supported
        if (inst.raw[1:0] == 2'b11) begin
            case (inst.itype.opcode)
                OP_LOAD:   begin cls = cls_load;   imm = imm_i; end
                OP_STORE:  begin cls = cls_store;  imm = imm_s; end
                OP_BRANCH: begin cls = cls_branch; imm = imm_b; end
                OP_JAL:    begin cls = cls_jal;    imm = imm_j; end
                OP_JALR:   begin cls = cls_jalr;   imm = imm_i; end
                OP_LUI:    begin cls = cls_alu;    imm = imm_u; end
                OP_AUIPC:  begin cls = cls_alu;    imm = imm_u; end
                OP_OPIMM:  begin cls = cls_alu;    imm = imm_i; end
                OP_OP:     cls = cls_alu;
                OP_SYSTEM: cls = cls_system;
                default:   cls = cls_illegal;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Output register toward decode
    // ------------------------------------------------------------------------
    assign rsp.ready = ~out_valid | out_ready;
    assign accept    = rsp.valid & rsp.ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_pc    <= rsp.pc;
            out_fault <= rsp.fault;
            // Faulted fetch carries no usable word
            out_inst  <= rsp.fault ? 32'd0 : inst.raw;
            out_class <= rsp.fault ? cls_illegal : cls;
            out_imm   <= rsp.fault ? 32'd0 : imm;
        end
    end

    // Consumed by decode, PC may advance
    assign retire = out_valid & out_ready;

endmodule

// File: hdl/axi_fetch_port.sv
`include "fetch_params.svh"

module axi_fetch_port (
    input  logic                      clock,
    input  logic                      reset,

    // Request from the PC generator
    input  logic                      fetch_req,
    input  logic [`FETCH_ADDR_W-1:0]  fetch_addr,
    output logic                      fetch_issue,

    // AXI4 read address channel
    input  logic                      arready,
    output logic                      arvalid,
    output logic [`FETCH_ADDR_W-1:0]  araddr,
    output logic [`FETCH_AXI_ID_W-1:0] arid,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic [1:0]                arburst,

    // AXI4 read data channel
    input  logic                      rvalid,
    input  logic [31:0]               rdata,
    input  axi_pkg::axi_resp_e        rresp,
    input  logic                      rlast,
    input  logic [`FETCH_AXI_ID_W-1:0] rid,
    output logic                      rready,

    fetch_rsp_if.source               rsp
);

    import axi_pkg::*;

    logic                     busy;
    logic                     beat;
    logic                     bad_beat;
    logic [`FETCH_ADDR_W-1:0] req_addr;

    // ------------------------------------------------------------------------
    // Read address channel, single word, fixed burst
    // ------------------------------------------------------------------------
    assign arvalid     = fetch_req & ~busy;
    assign araddr      = fetch_addr;
    assign arid        = '0;
    assign arlen       = 8'd0;
    assign arsize      = AXI_SIZE_4B;
    assign arburst     = fixed;
    assign fetch_issue = arvalid & arready;

    // One read in flight at most
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (fetch_issue) begin
            busy <= 1'b1;
        end else if (beat) begin
            busy <= 1'b0;
        end
    end

    // Address of the read in flight, returned with the word
    always_ff @(posedge clock) begin
        if (fetch_issue) begin
            req_addr <= fetch_addr;
        end
    end

    // ------------------------------------------------------------------------
    // Read data channel into the one-entry buffer
    // ------------------------------------------------------------------------
    assign rready = ~rsp.valid;
    assign beat   = rvalid & rready;

    // Error response, or a beat that does not match the single-beat read
    assign bad_beat = (rresp == slverr) || (rresp == decerr) || !rlast || (rid != arid);

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else if (beat) begin
            rsp.valid <= 1'b1;
        end else if (rsp.ready) begin
            rsp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (beat) begin
            rsp.pc    <= req_addr;
            rsp.word  <= rdata;
            rsp.fault <= bad_beat;
        end
    end

endmodule

// File: hdl/pc_gen.sv
`include "fetch_params.svh"

module pc_gen (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     retire,
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    input  logic                     replay,
    input  logic                     fetch_issue,
    output logic [`FETCH_ADDR_W-1:0] fetch_addr,
    output logic                     fetch_req
);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] next_pc;
    logic [`FETCH_ADDR_W-1:0] redirect_target;
    logic                     redirect_pend;
    logic                     replay_pend;
    logic                     capture;
    logic                     sel_redirect;
    logic                     sel_replay;
    logic                     started;

    // ------------------------------------------------------------------------
    // Redirect and replay capture
    // ------------------------------------------------------------------------

    // Only the first request is kept until retire
    assign capture = ~redirect_pend & ~replay_pend;

    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_pend <= 1'b0;
            replay_pend   <= 1'b0;
        end else if (retire) begin
            redirect_pend <= 1'b0;
            replay_pend   <= 1'b0;
        end else if (capture) begin
            redirect_pend <= redirect_valid;
            replay_pend   <= replay;
        end
    end

    always_ff @(posedge clock) begin
        if (capture && redirect_valid) begin
            redirect_target <= redirect_pc;
        end
    end

    // A request arriving together with retire still counts
    assign sel_redirect = redirect_pend | (capture & redirect_valid);
    assign sel_replay   = replay_pend | (capture & replay);

    // ------------------------------------------------------------------------
    // Next PC, redirect over replay over sequential
    // ------------------------------------------------------------------------
    always_comb begin
        if (sel_redirect) begin
            next_pc = redirect_pend ? redirect_target : redirect_pc;
        end else if (sel_replay) begin
            next_pc = pc;
        end else begin
            next_pc = pc + `FETCH_ADDR_W'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `FETCH_RESET_PC;
        end else if (retire) begin
            pc <= next_pc;
        end
    end

    // Request flag, raised once after reset and again on every retire
    always_ff @(posedge clock) begin
        if (reset) begin
            started   <= 1'b0;
            fetch_req <= 1'b0;
        end else begin
            started <= 1'b1;
            if (!started || retire) begin
                fetch_req <= 1'b1;
            end else if (fetch_issue) begin
                fetch_req <= 1'b0;
            end
        end
    end

    assign fetch_addr = pc;

endmodule

// File: hdl/fetch_rsp_if.sv
`include "fetch_params.svh"

interface fetch_rsp_if;

    logic                     valid;
    logic                     ready;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [31:0]              word;
    // Bus error or malformed beat
    logic                     fault;

    // Bus port side
    modport source (output valid, pc, word, fault, input ready);

    // Predecoder side
    modport sink (input valid, pc, word, fault, output ready);

endinterface

// File: hdl/axi_pkg.sv
package axi_pkg;

    // Response codes on R and B
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // Burst types, 2'b11 is reserved
    typedef enum logic [1:0] {
        fixed = 2'b00,
        incr  = 2'b01,
        wrap  = 2'b10
    } axi_burst_e;

    // AxSIZE code for one 32-bit word per beat
    localparam logic [2:0] AXI_SIZE_4B = 3'b010;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // Major opcodes of the base integer set
    // ------------------------------------------------------------------------
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Coarse class handed to decode
    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_system,
        cls_illegal
    } inst_class_e;

    // ------------------------------------------------------------------------
    // Instruction formats, msb first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } stype_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } btype_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } utype_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_t;

    // One word, read in whichever format the opcode calls for
    typedef union packed {
        logic [31:0] raw;
        itype_t      itype;
        stype_t      stype;
        btype_t      btype;
        utype_t      utype;
        jtype_t      jtype;
    } rv_inst_t;

endpackage

// File: hdl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// First fetch address after reset
`define FETCH_RESET_PC 32'h3000_0000

// Bus address width
`define FETCH_ADDR_W 32

// Width of arid and rid
`define FETCH_AXI_ID_W 4

`endif
